/* files.f */
+incdir+hdl
+incdir+testbench
hdl/board_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/cmd_engine.sv
hdl/board_wrapper.sv
testbench/tb_board_wrapper.sv

/* hdl/board_defs.svh */
/* Timing and sizing constants. CLKS_PER_BIT should be even and at least 4,
   REG_DEPTH a power of two so the address byte maps onto it by its low bits. */
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// ----------------------------------------------------------
// UART timing
// ----------------------------------------------------------

// Clock cycles per serial bit
`define CLKS_PER_BIT 8

// ----------------------------------------------------------
// Scratch register file
// ----------------------------------------------------------

`define REG_DEPTH 16

`endif

/* hdl/board_pkg.sv */
/* Shared types of the UART command subsystem.
   The register index width follows REG_DEPTH. */
`include "board_defs.svh"

package board_pkg;

   // One byte on the serial line and on both handshakes
   typedef logic [7:0] uart_byte_t;

   // Register index, low bits of the address byte
   typedef logic [$clog2(`REG_DEPTH)-1:0] reg_addr_t;

   // Opcode bytes in ASCII
   typedef enum logic [7:0] {
      OP_WRITE = 8'h57,
      OP_READ  = 8'h52
   } cmd_op_t;

   // Reply bytes
   localparam uart_byte_t REPLY_OK  = 8'h4B;
   localparam uart_byte_t REPLY_BAD = 8'h3F;

endpackage

/* hdl/board_wrapper.sv */
/* Board top on a single clock with synchronous active-high reset.
   Pads are plain logic pins, idle high, 8N1 frames of CLKS_PER_BIT cycles per bit. */
`timescale 1ns/100ps

module board_wrapper (
   input  logic clk,
   input  logic rst,
   input  logic uart_rx_pad,
   output logic uart_tx_pad
);
   import board_pkg::*;

   logic       rx_req;
   logic       rx_ack;
   uart_byte_t rx_data;
   logic       tx_req;
   logic       tx_ack;
   uart_byte_t tx_data;

   // ----------------------------------------------------------
   // Serial in
   // ----------------------------------------------------------

   uart_rx i_uart_rx (
      .clk     ( clk         ),
      .rst     ( rst         ),
      .rxd     ( uart_rx_pad ),
      .rx_req  ( rx_req      ),
      .rx_ack  ( rx_ack      ),
      .rx_data ( rx_data     )
   );

   // ----------------------------------------------------------
   // Command core
   // ----------------------------------------------------------

   cmd_engine i_cmd_engine (
      .clk     ( clk     ),
      .rst     ( rst     ),
      .rx_req  ( rx_req  ),
      .rx_ack  ( rx_ack  ),
      .rx_data ( rx_data ),
      .tx_req  ( tx_req  ),
      .tx_ack  ( tx_ack  ),
      .tx_data ( tx_data )
   );

   // Serial out
   uart_tx i_uart_tx (
      .clk     ( clk         ),
      .rst     ( rst         ),
      .tx_req  ( tx_req      ),
      .tx_ack  ( tx_ack      ),
      .tx_data ( tx_data     ),
      .txd     ( uart_tx_pad )
   );

endmodule

/* hdl/cmd_engine.sv */
/* Serves 'W' addr data and 'R' addr on a scratch register file; only the low
   address bits are used. No byte is taken while a reply is still pending. */
`timescale 1ns/100ps
`include "board_defs.svh"

module cmd_engine (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  rx_req,
   output logic                  rx_ack,
   input  board_pkg::uart_byte_t rx_data,
   output logic                  tx_req,
   input  logic                  tx_ack,
   output board_pkg::uart_byte_t tx_data
);
   import board_pkg::*;

   typedef enum logic [2:0] {
      ST_OPCODE,
      ST_ADDR,
      ST_DATA,
      ST_REPLY,
      ST_RELEASE
   } eng_state_t;

   eng_state_t state;
   cmd_op_t    op_q;
   reg_addr_t  addr_q;
   reg_addr_t  rx_addr;
   uart_byte_t reply_q;
   uart_byte_t regs [`REG_DEPTH];
   logic       collecting;
   logic       rx_take;

   // ----------------------------------------------------------
   // Receive side handshake
   // ----------------------------------------------------------

   assign collecting = (state == ST_OPCODE) || (state == ST_ADDR) || (state == ST_DATA);

   // A byte is taken on the first cycle rx_req is seen
   assign rx_take = collecting && rx_req && !rx_ack;
   assign rx_addr = rx_data[$bits(reg_addr_t)-1:0];

   always_ff @(posedge clk) begin
      if (rst) begin
         rx_ack <= 1'b0;
      end else if (rx_take) begin
         rx_ack <= 1'b1;
      end else if (rx_ack && !rx_req) begin
         rx_ack <= 1'b0;
      end
   end

   // ----------------------------------------------------------
   // Command FSM
   // ----------------------------------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         state  <= ST_OPCODE;
         op_q   <= OP_READ;
         tx_req <= 1'b0;
      end else begin
         case (state)
            ST_OPCODE: begin
               if (rx_take) begin
                  if (rx_data == OP_WRITE || rx_data == OP_READ) begin
                     op_q  <= cmd_op_t'(rx_data);
                     state <= ST_ADDR;
                  end else begin
                     // Unknown opcode, answer at once
                     state <= ST_REPLY;
                  end
               end
            end
            ST_ADDR: begin
               if (rx_take) begin
                  state <= (op_q == OP_READ) ? ST_REPLY : ST_DATA;
               end
            end
            ST_DATA: begin
               if (rx_take) begin
                  state <= ST_REPLY;
               end
            end
            ST_REPLY: begin
               // Hold the request until the transmitter loads the byte
               if (tx_req && tx_ack) begin
                  tx_req <= 1'b0;
                  state  <= ST_RELEASE;
               end else begin
                  tx_req <= 1'b1;
               end
            end
            ST_RELEASE: begin
               if (!tx_ack) begin
                  state <= ST_OPCODE;
               end
            end
            default: begin
               state <= ST_OPCODE;
            end
         endcase
      end
   end

   // Reply byte and address; later bytes of a valid command overwrite the reply
   always_ff @(posedge clk) begin
      if (rx_take) begin
         case (state)
            ST_OPCODE: begin
               reply_q <= REPLY_BAD;
            end
            ST_ADDR: begin
               addr_q  <= rx_addr;
               reply_q <= regs[rx_addr];
            end
            ST_DATA: begin
               reply_q <= REPLY_OK;
            end
            default: begin
            end
         endcase
      end
   end

   // ----------------------------------------------------------
   // Scratch registers
   // ----------------------------------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `REG_DEPTH; i++) begin
            regs[i] <= '0;
         end
      end else if (rx_take && state == ST_DATA) begin
         regs[addr_q] <= rx_data;
      end
   end

   assign tx_data = reply_q;

endmodule

/* hdl/uart_rx.sv */
/* 8N1 receiver, LSB first, with no overrun detection. The host has to wait for
   each reply before the next command; frames with a bad stop bit are dropped. */
`timescale 1ns/100ps
`include "board_defs.svh"

module uart_rx (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  rxd,
   output logic                  rx_req,
   input  logic                  rx_ack,
   output board_pkg::uart_byte_t rx_data
);
   import board_pkg::*;

   localparam int CNT_W = $clog2(`CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`CLKS_PER_BIT / 2 - 1);
   localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`CLKS_PER_BIT - 1);

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP,
      RX_HANDSHAKE
   } rx_state_t;

   rx_state_t        state;
   logic             rxd_meta;
   logic             rxd_sync;
   logic             rxd_prev;
   logic [CNT_W-1:0] cnt;
   logic [2:0]       bit_idx;
   uart_byte_t       shift_q;

   // Two-flop synchronizer, third stage for edge detection
   always_ff @(posedge clk) begin
      if (rst) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_prev <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= RX_IDLE;
         cnt     <= '0;
         bit_idx <= '0;
         rx_req  <= 1'b0;
      end else begin
         case (state)
            RX_IDLE: begin
               cnt <= '0;
               // Falling edge marks a start bit
               if (rxd_prev && !rxd_sync) begin
                  state <= RX_START;
               end
            end
            RX_START: begin
               if (cnt == HALF_BIT) begin
                  cnt     <= '0;
                  bit_idx <= '0;
                  // Line back high at mid-bit means a glitch
                  state   <= rxd_sync ? RX_IDLE : RX_DATA;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (cnt == FULL_BIT) begin
                  cnt     <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     state <= RX_STOP;
                  end
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            RX_STOP: begin
               if (cnt == FULL_BIT) begin
                  cnt <= '0;
                  if (rxd_sync) begin
                     rx_req <= 1'b1;
                     state  <= RX_HANDSHAKE;
                  end else begin
                     state <= RX_IDLE;
                  end
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            RX_HANDSHAKE: begin
               if (rx_req && rx_ack) begin
                  rx_req <= 1'b0;
               end else if (!rx_req && !rx_ack) begin
                  // Start bit of a back-to-back frame may already be on the line
                  state <= rxd_sync ? RX_IDLE : RX_START;
               end
            end
            default: begin
               state <= RX_IDLE;
            end
         endcase
      end
   end

   // Data bits arrive LSB first, sampled mid-bit
   always_ff @(posedge clk) begin
      if (state == RX_DATA && cnt == FULL_BIT) begin
         shift_q <= {rxd_sync, shift_q[7:1]};
      end
   end

   assign rx_data = shift_q;

endmodule

/* hdl/uart_tx.sv */
/* 8N1 transmitter, LSB first. One request sends exactly one frame; a new byte
   is taken only after the previous handshake has fully released. */
`timescale 1ns/100ps
`include "board_defs.svh"

module uart_tx (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  tx_req,
   output logic                  tx_ack,
   input  board_pkg::uart_byte_t tx_data,
   output logic                  txd
);
   import board_pkg::*;

   localparam int CNT_W = $clog2(`CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`CLKS_PER_BIT - 1);

   typedef enum logic [2:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP,
      TX_DONE
   } tx_state_t;

   tx_state_t        state;
   logic [CNT_W-1:0] cnt;
   logic [2:0]       bit_idx;
   logic             txd_q;
   logic             load;
   uart_byte_t       shift_q;

   assign load = (state == TX_IDLE) && tx_req && !tx_ack;

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= TX_IDLE;
         cnt     <= '0;
         bit_idx <= '0;
         tx_ack  <= 1'b0;
         txd_q   <= 1'b1;
      end else begin
         // Ack falls as soon as the requester lets go
         if (tx_ack && !tx_req) begin
            tx_ack <= 1'b0;
         end
         case (state)
            TX_IDLE: begin
               txd_q   <= 1'b1;
               cnt     <= '0;
               bit_idx <= '0;
               if (load) begin
                  tx_ack <= 1'b1;
                  state  <= TX_START;
               end
            end
            TX_START: begin
               txd_q <= 1'b0;
               if (cnt == FULL_BIT) begin
                  cnt   <= '0;
                  state <= TX_DATA;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            TX_DATA: begin
               txd_q <= shift_q[0];
               if (cnt == FULL_BIT) begin
                  cnt     <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     state <= TX_STOP;
                  end
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            TX_STOP: begin
               txd_q <= 1'b1;
               if (cnt == FULL_BIT) begin
                  cnt   <= '0;
                  state <= TX_DONE;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            TX_DONE: begin
               txd_q <= 1'b1;
               // Wait for the four-phase exchange to close
               if (!tx_req && !tx_ack) begin
                  state <= TX_IDLE;
               end
            end
            default: begin
               state <= TX_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         shift_q <= tx_data;
      end else if (state == TX_DATA && cnt == FULL_BIT) begin
         shift_q <= {1'b1, shift_q[7:1]};
      end
   end

   assign txd = txd_q;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# The exit status is zero only when the simulation passes.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -j 0 \
   -f files.f --top-module tb_board_wrapper -o sim_board \
   && ./obj_dir/sim_board \
   || { echo "Simulation build or run failed"; exit 1; }

exit 0

/* testbench/tb_tasks.svh */
/* Included inside the testbench module body. Relies on clk, uart_rx_pad,
   uart_tx_pad and lfsr_state being declared before the include. */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Reply frame must start within this many cycles of the command start
localparam int RECV_TIMEOUT_CYCLES = 5 * 10 * `CLKS_PER_BIT;

// ------------------------------------------------------------
// Random numbers
// ------------------------------------------------------------

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
   return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic rand_bits(input int nbits, output uart_byte_t value);
   value = '0;
   for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = {value[6:0], lfsr_state[0]};
   end
endtask

// ------------------------------------------------------------
// Compare
// ------------------------------------------------------------

task automatic check_value(input string name, input uart_byte_t exp, input uart_byte_t act);
   if (exp !== act) begin
      $display("ERR %s expected %02h actual %02h", name, exp, act);
      $display("Checks failed");
      $fatal(1, "Mismatch in %s", name);
   end
endtask

// ------------------------------------------------------------
// Serial line
// ------------------------------------------------------------

// One 8N1 frame, LSB first, changed on falling edges only
task automatic send_byte(input uart_byte_t b);
   logic [9:0] frame;
   frame = {1'b1, b, 1'b0};
   for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      uart_rx_pad = frame[i];
      repeat (`CLKS_PER_BIT - 1) @(negedge clk);
   end
endtask

task automatic recv_byte(output uart_byte_t b);
   int waited;
   waited = 0;
   b      = '0;
   @(negedge clk);
   while (uart_tx_pad !== 1'b0) begin
      if (waited == RECV_TIMEOUT_CYCLES) begin
         $display("Checks failed");
         $fatal(1, "No reply frame started within %0d cycles", RECV_TIMEOUT_CYCLES);
      end
      waited++;
      @(negedge clk);
   end
   // Move to the middle of the start bit
   repeat (`CLKS_PER_BIT / 2) @(negedge clk);
   check_value("reply start bit", 8'h00, {7'h00, uart_tx_pad});
   for (int i = 0; i < 8; i++) begin
      repeat (`CLKS_PER_BIT) @(negedge clk);
      b[i] = uart_tx_pad;
   end
   repeat (`CLKS_PER_BIT) @(negedge clk);
   check_value("reply stop bit", 8'h01, {7'h00, uart_tx_pad});
endtask

`endif

/* testbench/tb_board_wrapper.sv */
/* Drives commands on uart_rx_pad and checks each reply against a register model.
   The host waits for every reply before it sends the next command. */
`timescale 1ns/100ps
`include "board_defs.svh"

module tb_board_wrapper;
   import board_pkg::*;

   // Commands issued over all tests, used to size the watchdog
   localparam int     NUM_CMDS    = 256;
   localparam longint WATCHDOG_NS = longint'(NUM_CMDS) * 6 * 10 * `CLKS_PER_BIT * 8
                                    + 20 * `CLKS_PER_BIT * 8 + 10000;

   logic        clk;
   logic        rst;
   logic        uart_rx_pad;
   logic        uart_tx_pad;
   logic [31:0] lfsr_state;
   uart_byte_t  model_regs [`REG_DEPTH];

`include "tb_tasks.svh"

   always #4 clk = ~clk;

   board_wrapper i_board_wrapper (
      .clk         ( clk         ),
      .rst         ( rst         ),
      .uart_rx_pad ( uart_rx_pad ),
      .uart_tx_pad ( uart_tx_pad )
   );

   initial begin
      #(WATCHDOG_NS);
      $display("Checks failed");
      $fatal(1, "Watchdog expired before the test sequence finished");
   end

   // ------------------------------------------------------------
   // Reference model and command helpers
   // ------------------------------------------------------------

   // Only the low address bits select a register
   task automatic model_apply(input uart_byte_t op, input uart_byte_t addr,
                              input uart_byte_t data, output uart_byte_t reply);
      reg_addr_t idx;
      idx = reg_addr_t'(addr);
      if (op == OP_WRITE) begin
         model_regs[idx] = data;
         reply           = REPLY_OK;
      end else if (op == OP_READ) begin
         reply = model_regs[idx];
      end else begin
         reply = REPLY_BAD;
      end
   endtask

   task automatic run_and_check(input string name, input uart_byte_t op,
                                input uart_byte_t addr, input uart_byte_t data);
      uart_byte_t exp;
      uart_byte_t got;
      model_apply(op, addr, data, exp);
      fork
         begin
            send_byte(op);
            if (op == OP_WRITE || op == OP_READ) begin
               send_byte(addr);
            end
            if (op == OP_WRITE) begin
               send_byte(data);
            end
         end
         recv_byte(got);
      join
      check_value(name, exp, got);
   endtask

   task automatic pick_bad_opcode(output uart_byte_t op);
      do begin
         rand_bits(8, op);
      end while (op == OP_WRITE || op == OP_READ);
   endtask

   task automatic read_all(input string name);
      for (int a = 0; a < `REG_DEPTH; a++) begin
         run_and_check(name, OP_READ, 8'(a), 8'h00);
      end
   endtask

   // ------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------

   initial begin
      uart_byte_t op;
      uart_byte_t addr;
      uart_byte_t data;
      uart_byte_t sel;
      clk         = 1'b0;
      rst         = 1'b1;
      uart_rx_pad = 1'b1;
      lfsr_state  = 32'd85853;
      for (int i = 0; i < `REG_DEPTH; i++) begin
         model_regs[i] = 8'h00;
      end
      repeat (2) @(negedge clk);
      rst = 1'b0;

      // Idle line after reset, then all registers read as zero
      repeat (20 * `CLKS_PER_BIT) begin
         @(negedge clk);
         check_value("idle after reset", 8'h01, {7'h00, uart_tx_pad});
      end
      read_all("reset readback");

      run_and_check("directed write", OP_WRITE, 8'h03, 8'hA5);
      run_and_check("directed read", OP_READ, 8'h03, 8'h00);

      run_and_check("alias write", OP_WRITE, 8'h13, 8'h5C);
      run_and_check("alias read", OP_READ, 8'h03, 8'h00);

      repeat (4) begin
         pick_bad_opcode(op);
         run_and_check("bad opcode", op, 8'h00, 8'h00);
      end
      read_all("bad opcode readback");

      for (int n = 0; n < 200; n++) begin
         rand_bits(2, sel);
         rand_bits(8, addr);
         rand_bits(8, data);
         case (sel)
            8'd0, 8'd1: op = OP_WRITE;
            8'd2:       op = OP_READ;
            default:    pick_bad_opcode(op);
         endcase
         run_and_check("random mix", op, addr, data);
      end
      read_all("final readback");

      $display("All checks passed");
      $finish;
   end

endmodule
